// File: common/periph_pkg.sv
package periph_pkg;

    // ------------------------------------------------------------
    // Bus and register widths
    // ------------------------------------------------------------
    localparam int DataWidth   = 32;
    localparam int OffsetWidth = 12;  // Register offset inside one slot
    localparam int SlotWidth   = 4;   // Slot select above the offset
    localparam int PrioWidth   = 3;

    typedef logic [DataWidth-1:0]   data_t;
    typedef logic [DataWidth/8-1:0] strb_t;
    typedef logic [OffsetWidth-1:0] offset_t;
    typedef logic [SlotWidth-1:0]   slot_t;
    typedef logic [PrioWidth-1:0]   prio_t;

    // Slot map, all other slots answer with an error
    localparam slot_t SlotPlic = slot_t'(0);
    localparam slot_t SlotGpio = slot_t'(1);

    localparam data_t ErrorWord = 32'hDEAD_BEEF;

    // AXI response codes
    localparam logic [1:0] RespOkay   = 2'd0;
    localparam logic [1:0] RespSlvErr = 2'd2;

    // Front end FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,
        ST_RRESP
    } axil_state_e;

    // PLIC register map, priority of source n sits at 4*n
    localparam offset_t PlicPendingOfs   = 12'h080;
    localparam offset_t PlicEnableOfs    = 12'h100;
    localparam offset_t PlicThresholdOfs = 12'h200;
    localparam offset_t PlicClaimOfs     = 12'h204;

    // GPIO register map
    localparam offset_t GpioLedOfs     = 12'h000;  // Write LEDs, read DIP switches
    localparam offset_t GpioLedReadOfs = 12'h008;

endpackage

// File: plic/plic_core.sv
`timescale 1ns/1ps

module plic_core #(
    parameter int NumSources = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Register slot
    input  logic                  valid_i,
    input  logic                  write_i,
    input  periph_pkg::offset_t   offset_i,
    input  periph_pkg::data_t     wdata_i,
    output periph_pkg::data_t     rdata_o,
    // Interrupt pins, bit n-1 is source id n
    input  logic [NumSources-1:0] irq_src_i,
    output logic                  irq_o
);

    localparam int IdWidth = $clog2(NumSources + 1);

    periph_pkg::prio_t    prio_q [1:NumSources];
    logic [NumSources:1]  enable_q;
    logic [NumSources:1]  pending_q;
    logic [NumSources:1]  in_service_q;
    periph_pkg::prio_t    threshold_q;
    logic                 irq_q;

    periph_pkg::prio_t    best_prio;
    logic [IdWidth-1:0]   claim_id;  // 0 when nothing qualifies
    logic                 claim_rd;
    logic                 complete_wr;

    // ------------------------------------------------------------
    // Target selection
    // ------------------------------------------------------------
    always_comb
    begin
        best_prio = threshold_q;  // Must beat the threshold
        claim_id  = '0;
        for (int n = 1; n <= NumSources; n++)
        begin
            // Strictly greater so ties keep the lowest id
            if (pending_q[n] && enable_q[n] && (prio_q[n] > best_prio))
            begin
                best_prio = prio_q[n];
                claim_id  = IdWidth'(n);
            end
        end
    end

    assign claim_rd    = valid_i && !write_i && (offset_i == periph_pkg::PlicClaimOfs);
    assign complete_wr = valid_i && write_i && (offset_i == periph_pkg::PlicClaimOfs);

    // Register read mux
    always_comb
    begin
        rdata_o = '0;
        for (int n = 1; n <= NumSources; n++)
        begin
            if (offset_i == periph_pkg::offset_t'(4 * n))
                rdata_o = periph_pkg::data_t'(prio_q[n]);
        end
        case (offset_i)
            periph_pkg::PlicPendingOfs:   rdata_o = periph_pkg::data_t'({pending_q, 1'b0});
            periph_pkg::PlicEnableOfs:    rdata_o = periph_pkg::data_t'({enable_q, 1'b0});
            periph_pkg::PlicThresholdOfs: rdata_o = periph_pkg::data_t'(threshold_q);
            periph_pkg::PlicClaimOfs:     rdata_o = periph_pkg::data_t'(claim_id);
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // State update
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int n = 1; n <= NumSources; n++)
                prio_q[n] <= '0;
            enable_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            threshold_q  <= '0;
            irq_q        <= 1'b0;
        end
        else
        begin
            irq_q <= (claim_id != '0);
            if (valid_i && write_i)
            begin
                for (int n = 1; n <= NumSources; n++)
                begin
                    if (offset_i == periph_pkg::offset_t'(4 * n))
                        prio_q[n] <= wdata_i[periph_pkg::PrioWidth-1:0];
                end
                if (offset_i == periph_pkg::PlicEnableOfs)
                    enable_q <= wdata_i[NumSources:1];
                if (offset_i == periph_pkg::PlicThresholdOfs)
                    threshold_q <= wdata_i[periph_pkg::PrioWidth-1:0];
            end
            for (int n = 1; n <= NumSources; n++)
            begin
                if (claim_rd && (claim_id == IdWidth'(n)))
                begin
                    pending_q[n]    <= 1'b0;
                    in_service_q[n] <= 1'b1;
                end
                else
                begin
                    // Level sources re-arm only once out of service
                    if (irq_src_i[n-1] && !in_service_q[n])
                        pending_q[n] <= 1'b1;
                    if (complete_wr && (wdata_i == periph_pkg::data_t'(n)))
                        in_service_q[n] <= 1'b0;
                end
            end
        end
    end

    assign irq_o = irq_q;

endmodule

// File: tb.f
common/periph_pkg.sv
verilog/axil_slave.sv
verilog/periph_decode.sv
plic/plic_core.sv
verilog/gpio_regs.sv
verilog/periph_top.sv
tb/periph_chk.sv
tb/tb_top.sv

// File: tb/periph_chk.sv
`timescale 1ns/1ps

module periph_chk (
    input logic              clk_i,
    input logic              rst_i,
    input logic              awready_i,
    input logic              wready_i,
    input logic              arready_i,
    input logic              bvalid_i,
    input logic              bready_i,
    input logic [1:0]        bresp_i,
    input logic              rvalid_i,
    input logic              rready_i,
    input periph_pkg::data_t rdata_i,
    input logic [1:0]        rresp_i,
    input logic              irq_i
);

    int error_count = 0;  // Failure tally

    // ------------------------------------------------------------
    // Responses hold until the master takes them
    // ------------------------------------------------------------
    bresp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
        else begin $error("Write response changed before bready"); error_count++; end

    rresp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
        else begin $error("Read response changed before rready"); error_count++; end

    // Response exactly one cycle after acceptance and never without it
    write_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        awready_i && wready_i |=> bvalid_i)
        else begin $error("No write response one cycle after acceptance"); error_count++; end

    write_origin: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(bvalid_i) |-> $past(awready_i && wready_i))
        else begin $error("Write response without acceptance"); error_count++; end

    read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        arready_i |=> rvalid_i)
        else begin $error("No read response one cycle after acceptance"); error_count++; end

    read_origin: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(rvalid_i) |-> $past(arready_i))
        else begin $error("Read response without acceptance"); error_count++; end

    // Interrupt quiet during reset
    irq_in_reset: assert property (@(posedge clk_i)
        rst_i && $past(rst_i) |-> !irq_i)
        else begin $error("irq_o high during reset"); error_count++; end

endmodule

bind periph_top periph_chk periph_chk_i (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .awready_i ( awready_o ),
    .wready_i  ( wready_o  ),
    .arready_i ( arready_o ),
    .bvalid_i  ( bvalid_o  ),
    .bready_i  ( bready_i  ),
    .bresp_i   ( bresp_o   ),
    .rvalid_i  ( rvalid_o  ),
    .rready_i  ( rready_i  ),
    .rdata_i   ( rdata_o   ),
    .rresp_i   ( rresp_o   ),
    .irq_i     ( irq_o     )
);

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int NumSrc    = 4;
    localparam int MaxCycles = 3000;  // About ten times the test length

    logic              clk_i;
    logic              rst_i;
    logic              awvalid_i;
    logic              awready_o;
    logic [15:0]       awaddr_i;
    logic              wvalid_i;
    logic              wready_o;
    periph_pkg::data_t wdata_i;
    periph_pkg::strb_t wstrb_i;
    logic              bvalid_o;
    logic              bready_i;
    logic [1:0]        bresp_o;
    logic              arvalid_i;
    logic              arready_o;
    logic [15:0]       araddr_i;
    logic              rvalid_o;
    logic              rready_i;
    periph_pkg::data_t rdata_o;
    logic [1:0]        rresp_o;
    logic [NumSrc-1:0] irq_src_i;
    logic              irq_o;
    logic [7:0]        leds_o;
    logic [7:0]        dip_sw_i;

    integer seed = 96466;
    int     cycle_count = 0;
    int     model_prio [1:NumSrc];
    int     model_threshold;

    periph_top periph_top_i (.*);

    always #5 clk_i = ~clk_i;

    // Run limit and checker watch
    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MaxCycles)
        begin
            $display("Timeout after %0d cycles with tests still running", cycle_count);
            stop_on_failure();
        end
        else if (periph_top_i.periph_chk_i.error_count != 0)
        begin
            $display("A protocol assertion in the checker failed");
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("Regression failed");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_value(input string name, input periph_pkg::data_t exp,
                               input periph_pkg::data_t got);
        assert (got === exp)
        else
        begin
            $display("Error %s expected %h got %h", name, exp, got);
            stop_on_failure();
        end
    endtask

    function automatic logic [15:0] plic_addr(input periph_pkg::offset_t ofs);
        return {periph_pkg::SlotPlic, ofs};
    endfunction

    function automatic logic [15:0] gpio_addr(input periph_pkg::offset_t ofs);
        return {periph_pkg::SlotGpio, ofs};
    endfunction

    // Highest priority above threshold wins, lowest id on a tie
    function automatic int expected_claim(input logic [NumSrc:1] pend,
                                          input logic [NumSrc:1] en);
        for (int p = 7; p > model_threshold; p--)
            for (int id = 1; id <= NumSrc; id++)
                if (pend[id] && en[id] && (model_prio[id] == p))
                    return id;
        return 0;
    endfunction

    // ------------------------------------------------------------
    // AXI4-Lite driver
    // ------------------------------------------------------------
    task automatic take_write_resp(output logic [1:0] resp);
        int delay;
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk_i);  // Hold bready low a while
        bready_i <= 1'b1;
        do
            @(posedge clk_i);
        while (!bvalid_o);
        resp = bresp_o;
        bready_i <= 1'b0;
    endtask

    task automatic take_read_resp(output periph_pkg::data_t data, output logic [1:0] resp);
        int delay;
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk_i);
        rready_i <= 1'b1;
        do
            @(posedge clk_i);
        while (!rvalid_o);
        data = rdata_o;
        resp = rresp_o;
        rready_i <= 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input periph_pkg::data_t data,
                             input periph_pkg::strb_t strb, output logic [1:0] resp);
        awaddr_i  <= addr;
        wdata_i   <= data;
        wstrb_i   <= strb;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        do
            @(posedge clk_i);
        while (!(awready_o && wready_o));
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        take_write_resp(resp);
    endtask

    task automatic read_reg(input logic [15:0] addr, output periph_pkg::data_t data,
                            output logic [1:0] resp);
        araddr_i  <= addr;
        arvalid_i <= 1'b1;
        do
            @(posedge clk_i);
        while (!arready_o);
        arvalid_i <= 1'b0;
        take_read_resp(data, resp);
    endtask

    // Write and read raised together, the write must go first
    task automatic write_read_race(input logic [15:0] waddr, input periph_pkg::data_t wdata,
                                   input logic [15:0] raddr, output logic [1:0] wresp,
                                   output periph_pkg::data_t rdata, output logic [1:0] rresp);
        awaddr_i  <= waddr;
        wdata_i   <= wdata;
        wstrb_i   <= 4'hF;
        araddr_i  <= raddr;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        arvalid_i <= 1'b1;
        do
            @(posedge clk_i);
        while (!(awready_o && wready_o));
        check_value("arready_o", 32'h0, arready_o);
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        take_write_resp(wresp);
        do
            @(posedge clk_i);
        while (!arready_o);
        arvalid_i <= 1'b0;
        take_read_resp(rdata, rresp);
    endtask

    task automatic wait_irq(input logic level);
        do
            @(posedge clk_i);
        while (irq_o !== level);
    endtask

    initial
    begin
        logic [1:0]        resp;
        logic [1:0]        wresp;
        periph_pkg::data_t rdata;
        periph_pkg::data_t data;
        periph_pkg::strb_t strb;
        logic [7:0]        dip;
        logic [7:0]        leds_exp;
        logic [15:0]       addr;
        logic [NumSrc:1]   pend;
        int                exp_id;

        clk_i     = 1'b0;
        rst_i     = 1'b1;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        bready_i  = 1'b0;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        rready_i  = 1'b0;
        irq_src_i = '0;
        dip_sw_i  = '0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        check_value("leds_o", 32'h0, leds_o);

        // GPIO LEDs and DIP switches
        for (int i = 0; i < 4; i++)
        begin
            data = $random(seed);
            strb = $random(seed) | 4'h1;
            write_reg(gpio_addr(periph_pkg::GpioLedOfs), data, strb, resp);
            check_value("bresp_o", periph_pkg::RespOkay, resp);
            leds_exp = data[7:0];
            check_value("leds_o", leds_exp, leds_o);
            read_reg(gpio_addr(periph_pkg::GpioLedReadOfs), rdata, resp);
            check_value("rdata_o", leds_exp, rdata);
            write_reg(gpio_addr(periph_pkg::GpioLedOfs), ~data, strb & 4'hE, resp);
            check_value("leds_o", leds_exp, leds_o);  // Byte 0 strobe clear
            dip = $random(seed);
            dip_sw_i <= dip;
            read_reg(gpio_addr(periph_pkg::GpioLedOfs), rdata, resp);
            check_value("rdata_o", dip, rdata);
        end

        // Unmapped slots and offsets
        for (int i = 0; i < 3; i++)
        begin
            addr = $random(seed);
            addr[15:12] = 4'(2 + i * 5);
            addr[1:0] = 2'b00;
            read_reg(addr, rdata, resp);
            check_value("rresp_o", periph_pkg::RespSlvErr, resp);
            check_value("rdata_o", 32'hDEADBEEF, rdata);
            write_reg(addr, $random(seed), 4'hF, resp);
            check_value("bresp_o", periph_pkg::RespSlvErr, resp);
            check_value("leds_o", leds_exp, leds_o);
        end
        read_reg(gpio_addr(12'h004), rdata, resp);
        check_value("rresp_o", periph_pkg::RespOkay, resp);
        check_value("rdata_o", 32'hDEADBEEF, rdata);

        // ------------------------------------------------------------
        // PLIC registers and target selection
        // ------------------------------------------------------------
        model_prio[1] = 2;  // Equal to threshold, never chosen
        model_prio[2] = 5;
        model_prio[3] = 5;
        model_prio[4] = 1;
        model_threshold = 2;
        for (int n = 1; n <= NumSrc; n++)
            write_reg(plic_addr(periph_pkg::offset_t'(4 * n)), model_prio[n], 4'hF, resp);
        for (int n = 1; n <= NumSrc; n++)
        begin
            read_reg(plic_addr(periph_pkg::offset_t'(4 * n)), rdata, resp);
            check_value("rdata_o", model_prio[n], rdata);
        end
        write_reg(plic_addr(periph_pkg::PlicEnableOfs), 32'h1E, 4'hF, resp);
        read_reg(plic_addr(periph_pkg::PlicEnableOfs), rdata, resp);
        check_value("rdata_o", 32'h1E, rdata);
        write_reg(plic_addr(periph_pkg::PlicThresholdOfs), model_threshold, 4'hF, resp);
        read_reg(plic_addr(periph_pkg::PlicThresholdOfs), rdata, resp);
        check_value("rdata_o", model_threshold, rdata);

        irq_src_i <= 4'hF;
        wait_irq(1'b1);
        pend = 4'hF;
        read_reg(plic_addr(periph_pkg::PlicPendingOfs), rdata, resp);
        check_value("rdata_o", {pend, 1'b0}, rdata);
        for (int k = 0; k < 3; k++)
        begin
            exp_id = expected_claim(pend, 4'hF);
            read_reg(plic_addr(periph_pkg::PlicClaimOfs), rdata, resp);
            check_value("rdata_o", exp_id, rdata);
            if (exp_id != 0)
                pend[exp_id] = 1'b0;
        end
        repeat (3) @(posedge clk_i);
        check_value("irq_o", 32'h0, irq_o);
        irq_src_i <= '0;
        write_reg(plic_addr(periph_pkg::PlicClaimOfs), 32'd2, 4'hF, resp);
        write_reg(plic_addr(periph_pkg::PlicClaimOfs), 32'd3, 4'hF, resp);

        // Claim and complete on source 3 alone
        write_reg(plic_addr(periph_pkg::PlicEnableOfs), 32'h08, 4'hF, resp);
        repeat (3) @(posedge clk_i);
        check_value("irq_o", 32'h0, irq_o);
        irq_src_i <= 4'b0100;
        wait_irq(1'b1);
        pend[3] = 1'b1;
        read_reg(plic_addr(periph_pkg::PlicClaimOfs), rdata, resp);
        check_value("rdata_o", expected_claim(pend, 4'b0100), rdata);
        pend[3] = 1'b0;
        wait_irq(1'b0);
        read_reg(plic_addr(periph_pkg::PlicPendingOfs), rdata, resp);
        check_value("rdata_o", {pend, 1'b0}, rdata);
        write_reg(plic_addr(periph_pkg::PlicClaimOfs), 32'd3, 4'hF, resp);
        wait_irq(1'b1);  // Level still high, so pending again
        pend[3] = 1'b1;
        read_reg(plic_addr(periph_pkg::PlicPendingOfs), rdata, resp);
        check_value("rdata_o", {pend, 1'b0}, rdata);
        read_reg(plic_addr(periph_pkg::PlicClaimOfs), rdata, resp);
        check_value("rdata_o", 32'd3, rdata);
        irq_src_i <= '0;
        write_reg(plic_addr(periph_pkg::PlicClaimOfs), 32'd3, 4'hF, resp);

        // Back-pressure with write and read pending together
        for (int i = 0; i < 6; i++)
        begin
            data = $random(seed);
            if (i % 2 == 0)
            begin
                write_read_race(gpio_addr(periph_pkg::GpioLedOfs), data,
                                gpio_addr(periph_pkg::GpioLedReadOfs), wresp, rdata, resp);
                check_value("rdata_o", data[7:0], rdata);
                check_value("leds_o", data[7:0], leds_o);
            end
            else
            begin
                addr = plic_addr(periph_pkg::offset_t'(4 * (i % NumSrc + 1)));
                write_read_race(addr, data, addr, wresp, rdata, resp);
                check_value("rdata_o", data[2:0], rdata);
            end
            check_value("bresp_o", periph_pkg::RespOkay, wresp);
            check_value("rresp_o", periph_pkg::RespOkay, resp);
        end

        repeat (2) @(posedge clk_i);
        if (periph_top_i.periph_chk_i.error_count == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("A protocol assertion in the checker failed");
            stop_on_failure();
        end
    end

endmodule

// File: verilog/axil_slave.sv
`timescale 1ns/1ps

module axil_slave #(
    parameter int AddrWidth = 16
) (
    input  logic                clk_i,
    input  logic                rst_i,
    // AXI4-Lite slave
    input  logic                awvalid_i,
    output logic                awready_o,
    input  logic [AddrWidth-1:0] awaddr_i,
    input  logic                wvalid_i,
    output logic                wready_o,
    input  periph_pkg::data_t   wdata_i,
    input  periph_pkg::strb_t   wstrb_i,
    output logic                bvalid_o,
    input  logic                bready_i,
    output logic [1:0]          bresp_o,
    input  logic                arvalid_i,
    output logic                arready_o,
    input  logic [AddrWidth-1:0] araddr_i,
    output logic                rvalid_o,
    input  logic                rready_i,
    output periph_pkg::data_t   rdata_o,
    output logic [1:0]          rresp_o,
    // Single-cycle register request
    output logic                req_valid_o,
    output logic                req_write_o,
    output logic [periph_pkg::OffsetWidth+periph_pkg::SlotWidth-1:0] req_addr_o,
    output periph_pkg::data_t   req_wdata_o,
    output periph_pkg::strb_t   req_wstrb_o,
    input  periph_pkg::data_t   rsp_rdata_i,
    input  logic                rsp_err_i
);

    localparam int ReqAddrWidth = periph_pkg::OffsetWidth + periph_pkg::SlotWidth;

    periph_pkg::axil_state_e state_q;
    logic                    write_go;
    logic                    read_go;
    periph_pkg::data_t       rdata_q;
    logic [1:0]              resp_q;

    // ------------------------------------------------------------
    // Acceptance, writes win over reads
    // ------------------------------------------------------------
    assign write_go = (state_q == periph_pkg::ST_IDLE) && awvalid_i && wvalid_i;
    assign read_go  = (state_q == periph_pkg::ST_IDLE) && !write_go && arvalid_i;

    assign awready_o = write_go;
    assign wready_o  = write_go;
    assign arready_o = read_go;

    // Request goes out in the acceptance cycle
    assign req_valid_o = write_go || read_go;
    assign req_write_o = write_go;
    assign req_addr_o  = write_go ? awaddr_i[ReqAddrWidth-1:0]
                                  : araddr_i[ReqAddrWidth-1:0];  // Upper bits ignored
    assign req_wdata_o = wdata_i;
    assign req_wstrb_o = wstrb_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= periph_pkg::ST_IDLE;
        end
        else
        begin
            case (state_q)
                periph_pkg::ST_IDLE:
                begin
                    if (write_go)
                        state_q <= periph_pkg::ST_WRESP;
                    else if (read_go)
                        state_q <= periph_pkg::ST_RRESP;
                end
                periph_pkg::ST_WRESP:
                begin
                    if (bready_i)
                        state_q <= periph_pkg::ST_IDLE;
                end
                periph_pkg::ST_RRESP:
                begin
                    if (rready_i)
                        state_q <= periph_pkg::ST_IDLE;
                end
                default: state_q <= periph_pkg::ST_IDLE;
            endcase
        end
    end

    // Response captured at acceptance, held until taken
    always_ff @(posedge clk_i)
    begin
        if (write_go || read_go)
        begin
            rdata_q <= rsp_rdata_i;
            resp_q  <= rsp_err_i ? periph_pkg::RespSlvErr : periph_pkg::RespOkay;
        end
    end

    assign bvalid_o = (state_q == periph_pkg::ST_WRESP);
    assign bresp_o  = resp_q;
    assign rvalid_o = (state_q == periph_pkg::ST_RRESP);
    assign rdata_o  = rdata_q;
    assign rresp_o  = resp_q;

endmodule

// File: verilog/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  logic                write_i,
    input  periph_pkg::offset_t offset_i,
    input  periph_pkg::data_t   wdata_i,
    input  periph_pkg::strb_t   wstrb_i,
    output periph_pkg::data_t   rdata_o,
    output logic [7:0]          leds_o,
    input  logic [7:0]          dip_sw_i
);

    logic [7:0] leds_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            leds_q <= '0;
        else if (valid_i && write_i && (offset_i == periph_pkg::GpioLedOfs) && wstrb_i[0])
            leds_q <= wdata_i[7:0];  // Only byte 0 matters
    end

    // Unmapped offsets read the error word but stay OKAY
    always_comb
    begin
        case (offset_i)
            periph_pkg::GpioLedOfs:     rdata_o = periph_pkg::data_t'(dip_sw_i);
            periph_pkg::GpioLedReadOfs: rdata_o = periph_pkg::data_t'(leds_q);
            default:                    rdata_o = periph_pkg::ErrorWord;
        endcase
    end

    assign leds_o = leds_q;

endmodule

// File: verilog/periph_decode.sv
`timescale 1ns/1ps

module periph_decode (
    // Request from the front end
    input  logic                req_valid_i,
    input  logic                req_write_i,
    input  logic [periph_pkg::OffsetWidth+periph_pkg::SlotWidth-1:0] req_addr_i,
    input  periph_pkg::data_t   req_wdata_i,
    input  periph_pkg::strb_t   req_wstrb_i,
    output periph_pkg::data_t   rsp_rdata_o,
    output logic                rsp_err_o,
    // PLIC slot
    output logic                plic_valid_o,
    input  periph_pkg::data_t   plic_rdata_i,
    // GPIO slot
    output logic                gpio_valid_o,
    input  periph_pkg::data_t   gpio_rdata_i,
    // Shared by all slots
    output logic                slot_write_o,
    output periph_pkg::offset_t slot_offset_o,
    output periph_pkg::data_t   slot_wdata_o,
    output periph_pkg::strb_t   slot_wstrb_o
);

    periph_pkg::slot_t slot;

    assign slot = req_addr_i[periph_pkg::OffsetWidth +: periph_pkg::SlotWidth];

    assign plic_valid_o = req_valid_i && (slot == periph_pkg::SlotPlic);
    assign gpio_valid_o = req_valid_i && (slot == periph_pkg::SlotGpio);

    assign slot_write_o  = req_write_i;
    assign slot_offset_o = req_addr_i[periph_pkg::OffsetWidth-1:0];
    assign slot_wdata_o  = req_wdata_i;
    assign slot_wstrb_o  = req_wstrb_i;

    // Read mux, unmapped slots answer here
    always_comb
    begin
        rsp_rdata_o = periph_pkg::ErrorWord;
        rsp_err_o   = 1'b1;
        case (slot)
            periph_pkg::SlotPlic:
            begin
                rsp_rdata_o = plic_rdata_i;
                rsp_err_o   = 1'b0;
            end
            periph_pkg::SlotGpio:
            begin
                rsp_rdata_o = gpio_rdata_i;
                rsp_err_o   = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter int AddrWidth  = 16,
    parameter int NumSources = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    // AXI4-Lite slave
    input  logic                    awvalid_i,
    output logic                    awready_o,
    input  logic [AddrWidth-1:0]    awaddr_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    input  periph_pkg::data_t       wdata_i,
    input  periph_pkg::strb_t       wstrb_i,
    output logic                    bvalid_o,
    input  logic                    bready_i,
    output logic [1:0]              bresp_o,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    input  logic [AddrWidth-1:0]    araddr_i,
    output logic                    rvalid_o,
    input  logic                    rready_i,
    output periph_pkg::data_t       rdata_o,
    output logic [1:0]              rresp_o,
    // Pins
    input  logic [NumSources-1:0]   irq_src_i,  // Bit n-1 is source id n
    output logic                    irq_o,
    output logic [7:0]              leds_o,
    input  logic [7:0]              dip_sw_i
);

    localparam int ReqAddrWidth = periph_pkg::OffsetWidth + periph_pkg::SlotWidth;

    // Register request path
    logic                    req_valid;
    logic                    req_write;
    logic [ReqAddrWidth-1:0] req_addr;
    periph_pkg::data_t       req_wdata;
    periph_pkg::strb_t       req_wstrb;
    periph_pkg::data_t       rsp_rdata;
    logic                    rsp_err;

    // Shared slot side
    logic                    plic_valid;
    logic                    gpio_valid;
    logic                    slot_write;
    periph_pkg::offset_t     slot_offset;
    periph_pkg::data_t       slot_wdata;
    periph_pkg::strb_t       slot_wstrb;
    periph_pkg::data_t       plic_rdata;
    periph_pkg::data_t       gpio_rdata;

    axil_slave #(
        .AddrWidth ( AddrWidth )
    ) axil_slave_i (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .awvalid_i   ( awvalid_i ),
        .awready_o   ( awready_o ),
        .awaddr_i    ( awaddr_i  ),
        .wvalid_i    ( wvalid_i  ),
        .wready_o    ( wready_o  ),
        .wdata_i     ( wdata_i   ),
        .wstrb_i     ( wstrb_i   ),
        .bvalid_o    ( bvalid_o  ),
        .bready_i    ( bready_i  ),
        .bresp_o     ( bresp_o   ),
        .arvalid_i   ( arvalid_i ),
        .arready_o   ( arready_o ),
        .araddr_i    ( araddr_i  ),
        .rvalid_o    ( rvalid_o  ),
        .rready_i    ( rready_i  ),
        .rdata_o     ( rdata_o   ),
        .rresp_o     ( rresp_o   ),
        .req_valid_o ( req_valid ),
        .req_write_o ( req_write ),
        .req_addr_o  ( req_addr  ),
        .req_wdata_o ( req_wdata ),
        .req_wstrb_o ( req_wstrb ),
        .rsp_rdata_i ( rsp_rdata ),
        .rsp_err_i   ( rsp_err   )
    );

    periph_decode periph_decode_i (
        .req_valid_i   ( req_valid   ),
        .req_write_i   ( req_write   ),
        .req_addr_i    ( req_addr    ),
        .req_wdata_i   ( req_wdata   ),
        .req_wstrb_i   ( req_wstrb   ),
        .rsp_rdata_o   ( rsp_rdata   ),
        .rsp_err_o     ( rsp_err     ),
        .plic_valid_o  ( plic_valid  ),
        .plic_rdata_i  ( plic_rdata  ),
        .gpio_valid_o  ( gpio_valid  ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .slot_write_o  ( slot_write  ),
        .slot_offset_o ( slot_offset ),
        .slot_wdata_o  ( slot_wdata  ),
        .slot_wstrb_o  ( slot_wstrb  )
    );

    plic_core #(
        .NumSources ( NumSources )
    ) plic_core_i (
        .clk_i     ( clk_i       ),
        .rst_i     ( rst_i       ),
        .valid_i   ( plic_valid  ),
        .write_i   ( slot_write  ),
        .offset_i  ( slot_offset ),
        .wdata_i   ( slot_wdata  ),
        .rdata_o   ( plic_rdata  ),
        .irq_src_i ( irq_src_i   ),
        .irq_o     ( irq_o       )
    );

    gpio_regs gpio_regs_i (
        .clk_i    ( clk_i       ),
        .rst_i    ( rst_i       ),
        .valid_i  ( gpio_valid  ),
        .write_i  ( slot_write  ),
        .offset_i ( slot_offset ),
        .wdata_i  ( slot_wdata  ),
        .wstrb_i  ( slot_wstrb  ),
        .rdata_o  ( gpio_rdata  ),
        .leds_o   ( leds_o      ),
        .dip_sw_i ( dip_sw_i    )
    );

endmodule
